/* flist.f */
hw/pack_pkg.sv
hw/word_packer.sv
hw/line_writer.sv
hw/line_ram.sv
hw/stream_to_mem.sv
tb/tb_clock_gen.sv
tb/tb_stream_to_mem.sv

/* hw/line_ram.sv */
`timescale 1ns/1ns

module line_ram import pack_pkg::*; (
  input  logic              clk,
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  logic [LINE_W-1:0] wr_data,
  input  logic [ADDR_W-1:0] rd_addr,
  output logic [LINE_W-1:0] rd_data
);

  logic [LINE_W-1:0] mem [LINE_DEPTH];

  // ##########################################################
  // Write port
  // ##########################################################
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ##########################################################
  // Read port
  // ##########################################################
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];   // One cycle latency
  end

endmodule

/* hw/line_writer.sv */
`timescale 1ns/1ns

module line_writer import pack_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               request_write,
  input  logic [LINE_W-1:0]  write_data,
  output logic               available_write,
  output logic               wr_en,
  output logic [ADDR_W-1:0]  wr_addr,
  output logic [LINE_W-1:0]  wr_data,
  output logic [COUNT_W-1:0] lines_written
);

  writer_state_t state;

  logic [$clog2(WRITE_BUSY_CYCLES)-1:0] busy_cnt;
  logic [ADDR_W-1:0]                    next_addr;

  assign available_write = (state == W_IDLE);

  // ##########################################################
  // Busy window
  // ##########################################################
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= W_IDLE;
      busy_cnt <= '0;
    end else begin
      case (state)
        W_IDLE: begin
          if (request_write) begin
            state    <= W_BUSY;
            busy_cnt <= $bits(busy_cnt)'(WRITE_BUSY_CYCLES - 1);
          end
        end
        W_BUSY: begin
          if (busy_cnt == '0) state <= W_IDLE;
          else busy_cnt <= busy_cnt - 1'b1;
        end
        default: state <= W_IDLE;
      endcase
    end
  end

  // ##########################################################
  // Memory write and line count
  // ##########################################################
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_en         <= 1'b0;
      next_addr     <= '0;
      lines_written <= '0;
    end else begin
      wr_en <= request_write;
      if (request_write) begin
        if (next_addr == ADDR_W'(LINE_DEPTH - 1)) next_addr <= '0;   // Wrap to line 0
        else next_addr <= next_addr + 1'b1;
      end
      // Counted as the line lands in memory, so a rise means it is readable
      if (wr_en) lines_written <= lines_written + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (request_write) begin
      wr_addr <= next_addr;
      wr_data <= write_data;
    end
  end

  a_request_when_free: assert property (
    @(posedge clk) disable iff (rst) request_write |-> available_write
  ) else $error("request_write while writer busy");

endmodule

/* hw/pack_pkg.sv */
package pack_pkg;

  // ##########################################################
  // Widths and sizes
  // ##########################################################
  localparam int IN_W           = 16;              // Pushed word
  localparam int LINE_W         = 512;             // Memory line
  localparam int WORDS_PER_LINE = LINE_W / IN_W;   // 32 words per line
  localparam int LINE_DEPTH     = 64;              // Lines in memory
  localparam int ADDR_W         = 6;
  localparam int COUNT_W        = 16;              // Lines-written counter

  // Writer stays busy this long after taking a line
  localparam int WRITE_BUSY_CYCLES = 8;

  // ##########################################################
  // State encodings
  // ##########################################################
  typedef enum logic [1:0] {
    FILL_A,    // A filling
    DRAIN_A,   // A full and waiting, B filling
    FILL_B,    // B filling
    DRAIN_B    // B full and waiting, A filling
  } packer_state_t;

  typedef enum logic {
    W_IDLE,
    W_BUSY
  } writer_state_t;

endpackage

/* hw/stream_to_mem.sv */
`timescale 1ns/1ns

module stream_to_mem import pack_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               push_data,
  input  logic [IN_W-1:0]    data_in,
  output logic               available_push,
  input  logic [ADDR_W-1:0]  rd_addr,
  output logic [LINE_W-1:0]  rd_data,
  output logic [COUNT_W-1:0] lines_written
);

  // Packer to writer
  logic              available_write;
  logic              request_write;
  logic [LINE_W-1:0] write_data;

  // Writer to memory
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  logic [LINE_W-1:0] wr_data;

  word_packer packer_i (
    .clk             (clk),
    .rst             (rst),
    .push_data       (push_data),
    .data_in         (data_in),
    .available_push  (available_push),
    .available_write (available_write),
    .request_write   (request_write),
    .write_data      (write_data)
  );

  line_writer writer_i (
    .clk             (clk),
    .rst             (rst),
    .request_write   (request_write),
    .write_data      (write_data),
    .available_write (available_write),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .lines_written   (lines_written)
  );

  line_ram ram_i (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

/* hw/word_packer.sv */
`timescale 1ns/1ns

module word_packer import pack_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              push_data,
  input  logic [IN_W-1:0]   data_in,
  output logic              available_push,
  input  logic              available_write,
  output logic              request_write,
  output logic [LINE_W-1:0] write_data
);

  packer_state_t state;

  logic [LINE_W-1:0]         line_buf [2];   // Index 0 is buffer A, 1 is buffer B
  logic [WORDS_PER_LINE-1:0] word_cnt [2];   // One-hot word position per buffer

  logic fill_idx;
  logic draining;
  logic last_word;
  logic other_full;
  logic in_flight;
  logic accept;

  logic req_stage;   // First pipeline stage of an accepted line
  logic req_sel;     // Buffer to present

  // ##########################################################
  // Buffer select and acceptance
  // ##########################################################
  assign fill_idx   = (state == FILL_B) || (state == DRAIN_A);
  assign draining   = (state == DRAIN_A) || (state == DRAIN_B);
  assign last_word  = push_data && word_cnt[fill_idx][WORDS_PER_LINE-1];
  assign other_full = !available_push || last_word;   // Fill buffer full or completing now

  // No new acceptance until the writer has seen the previous request
  assign in_flight = req_stage || request_write;
  assign accept    = draining && available_write && !in_flight;

  // ##########################################################
  // Word capture
  // ##########################################################
  always_ff @(posedge clk) begin
    if (push_data) begin
      line_buf[fill_idx] <= {data_in, line_buf[fill_idx][LINE_W-1:IN_W]};   // Shift in from top
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      word_cnt[0] <= WORDS_PER_LINE'(1);
      word_cnt[1] <= WORDS_PER_LINE'(1);
    end else if (push_data) begin
      // Rotate, so the count is back at word 0 after the 32nd push
      word_cnt[fill_idx] <= {word_cnt[fill_idx][WORDS_PER_LINE-2:0],
                             word_cnt[fill_idx][WORDS_PER_LINE-1]};
    end
  end

  // ##########################################################
  // Ping-pong FSM and push permission
  // ##########################################################
  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= FILL_A;
      available_push <= 1'b1;
    end else begin
      case (state)
        FILL_A: begin
          if (last_word) state <= DRAIN_A;
        end
        DRAIN_A: begin
          if (accept) state <= other_full ? DRAIN_B : FILL_B;
        end
        FILL_B: begin
          if (last_word) state <= DRAIN_B;
        end
        DRAIN_B: begin
          if (accept) state <= other_full ? DRAIN_A : FILL_A;
        end
        default: state <= FILL_A;
      endcase

      if (accept) begin
        available_push <= 1'b1;
      end else if (draining && last_word) begin
        available_push <= 1'b0;   // Both buffers now hold full lines
      end
    end
  end

  // ##########################################################
  // Request pipeline
  // ##########################################################
  always_ff @(posedge clk) begin
    if (rst) begin
      req_stage     <= 1'b0;
      request_write <= 1'b0;
    end else begin
      req_stage     <= accept;
      request_write <= req_stage;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) req_sel <= !fill_idx;   // Draining buffer
    if (req_stage) write_data <= line_buf[req_sel];
  end

  a_push_allowed: assert property (
    @(posedge clk) disable iff (rst) push_data |-> available_push
  ) else $error("push while available_push low");

  a_request_pulse: assert property (
    @(posedge clk) disable iff (rst) request_write |=> !request_write
  ) else $error("request_write high two cycles in a row");

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the stream_to_mem testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_stream_to_mem
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module "$top" -f flist.f
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/V"$top" > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "tests failed" "$log"; then
  echo "Result: FAIL"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if ! grep -q "all tests passed" "$log"; then
  echo "Result: FAIL, no pass line in $log"
  exit 1
fi

echo "Result: PASS"
exit 0

/* tb/stream_patterns.txt */
# P first_word(hex) words(dec) gaps(0/1), word i = first + (i/32)*100h + i%32
# W idle_cycles(dec) | C lines_written(dec) addr(hex) line(hex, word 31 leftmost)
P 10c0 32 1
C 1 00 10df10de10dd10dc10db10da10d910d810d710d610d510d410d310d210d110d010cf10ce10cd10cc10cb10ca10c910c810c710c610c510c410c310c210c110c0
P 11c0 128 0
C 2 01 11df11de11dd11dc11db11da11d911d811d711d611d511d411d311d211d111d011cf11ce11cd11cc11cb11ca11c911c811c711c611c511c411c311c211c111c0
C 3 02 12df12de12dd12dc12db12da12d912d812d712d612d512d412d312d212d112d012cf12ce12cd12cc12cb12ca12c912c812c712c612c512c412c312c212c112c0
C 5 04 14df14de14dd14dc14db14da14d914d814d714d614d514d414d314d214d114d014cf14ce14cd14cc14cb14ca14c914c814c714c614c514c414c314c214c114c0
W 20
P 15c0 960 1
C 35 22 32df32de32dd32dc32db32da32d932d832d732d632d532d432d332d232d132d032cf32ce32cd32cc32cb32ca32c932c832c732c632c532c432c332c232c132c0
P 33c0 960 0
C 64 3f 4fdf4fde4fdd4fdc4fdb4fda4fd94fd84fd74fd64fd54fd44fd34fd24fd14fd04fcf4fce4fcd4fcc4fcb4fca4fc94fc84fc74fc64fc54fc44fc34fc24fc14fc0
C 65 00 50df50de50dd50dc50db50da50d950d850d750d650d550d450d350d250d150d050cf50ce50cd50cc50cb50ca50c950c850c750c650c550c450c350c250c150c0
C 65 01 11df11de11dd11dc11db11da11d911d811d711d611d511d411d311d211d111d011cf11ce11cd11cc11cb11ca11c911c811c711c611c511c411c311c211c111c0
P 51c0 5 1
W 40

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #2 clk = ~clk;   // 4 ns period

endmodule

/* tb/tb_stream_to_mem.sv */
`timescale 1ns/1ns

module tb_stream_to_mem
  import pack_pkg::*;
();

  localparam string PATTERN_FILE    = "tb/stream_patterns.txt";
  localparam int    CYCLES_PER_UNIT = 64;   // Watchdog budget per record or pushed word

  logic               clk;
  logic               rst;
  logic               push_data;
  logic [IN_W-1:0]    data_in;
  logic               available_push;
  logic [ADDR_W-1:0]  rd_addr;
  logic [LINE_W-1:0]  rd_data;
  logic [COUNT_W-1:0] lines_written;

  // Records loaded from the pattern file
  byte               rec_kind [$];
  int                rec_x    [$];
  int                rec_y    [$];
  int                rec_z    [$];
  logic [LINE_W-1:0] rec_line [$];

  bit          loaded      = 1'b0;
  int          work_units  = 0;
  int          total_words = 0;
  logic [31:0] lfsr_state  = 32'hf69a2877;

  tb_clock_gen clk_gen_i (
    .clk (clk)
  );

  stream_to_mem dut_i (
    .clk            (clk),
    .rst            (rst),
    .push_data      (push_data),
    .data_in        (data_in),
    .available_push (available_push),
    .rd_addr        (rd_addr),
    .rd_data        (rd_data),
    .lines_written  (lines_written)
  );

  // ##########################################################
  // Helpers
  // ##########################################################
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [LINE_W-1:0] got,
                             input logic [LINE_W-1:0] expected);
    if (got !== expected) begin
      abort_run($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, expected));
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_gap(output int gap);
    gap = 0;
    repeat (2) begin
      lfsr_state = lfsr_next(lfsr_state);
      gap = (gap << 1) | int'(lfsr_state[0]);   // One step per bit
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic push_one(input int word);
    while (!available_push) begin
      @(posedge clk);
      #1;
    end
    push_data = 1'b1;
    data_in   = IN_W'(word);
    @(posedge clk);
    #1;
    push_data = 1'b0;   // Raised again at once by a following push
  endtask

  task automatic push_words(input int first, input int count, input bit use_gaps);
    int word;
    int gap;
    for (int i = 0; i < count; i++) begin
      word = first + (i / WORDS_PER_LINE) * 256 + (i % WORDS_PER_LINE);
      push_one(word);
      if (use_gaps) begin
        draw_gap(gap);
        idle_cycles(gap);
      end
    end
  endtask

  task automatic check_line(input int count, input int addr,
                            input logic [LINE_W-1:0] expected);
    while (int'(lines_written) < count) begin
      @(posedge clk);
      #1;
    end
    rd_addr = ADDR_W'(addr);
    @(posedge clk);
    #1;
    check_value($sformatf("rd_data[%0d]", addr), rd_data, expected);
  endtask

  task automatic load_patterns();
    int                fd;
    string             text;
    string             rest;
    byte               kind;
    int                x;
    int                y;
    int                z;
    logic [LINE_W-1:0] line_v;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) abort_run("Could not open the pattern file");
    while ($fgets(text, fd) != 0) begin
      kind = text.getc(0);
      rest = text.substr(1, text.len() - 1);
      x = 0;
      y = 0;
      z = 0;
      line_v = '0;
      if (kind == "#" || kind == "\n" || kind == " ") begin
        continue;   // Comment or blank line
      end else if (kind == "P") begin
        if ($sscanf(rest, "%h %d %d", x, y, z) != 3) abort_run("Malformed push record");
        work_units += y;
      end else if (kind == "W") begin
        if ($sscanf(rest, "%d", x) != 1) abort_run("Malformed wait record");
        work_units += x;
      end else if (kind == "C") begin
        if ($sscanf(rest, "%d %h %h", x, y, line_v) != 3) abort_run("Malformed check record");
      end else begin
        abort_run("Unknown record kind in the pattern file");
      end
      rec_kind.push_back(kind);
      rec_x.push_back(x);
      rec_y.push_back(y);
      rec_z.push_back(z);
      rec_line.push_back(line_v);
      work_units++;
    end
    $fclose(fd);
  endtask

  // ##########################################################
  // Watchdog
  // ##########################################################
  initial begin
    wait (loaded);
    repeat (work_units * CYCLES_PER_UNIT) @(posedge clk);
    abort_run($sformatf("The run timed out after %0d cycles",
                        work_units * CYCLES_PER_UNIT));
  end

  // ##########################################################
  // Main sequence
  // ##########################################################
  initial begin
    rst       = 1'b1;
    push_data = 1'b0;
    data_in   = '0;
    rd_addr   = '0;
    load_patterns();
    loaded = 1'b1;

    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    check_value("available_push", LINE_W'(available_push), LINE_W'(1));
    check_value("lines_written", LINE_W'(lines_written), LINE_W'(0));

    for (int r = 0; r < rec_kind.size(); r++) begin
      case (rec_kind[r])
        "P": begin
          push_words(rec_x[r], rec_y[r], rec_z[r] != 0);
          total_words += rec_y[r];
        end
        "W": idle_cycles(rec_x[r]);
        "C": check_line(rec_x[r], rec_y[r], rec_line[r]);
        default: abort_run("Unknown record kind in the loaded records");
      endcase
    end

    // Only complete lines reach memory
    check_value("lines_written", LINE_W'(lines_written),
                LINE_W'(total_words / WORDS_PER_LINE));

    $display("all tests passed");
    $finish;
  end

endmodule
